//--- Bender.yml
package:
  name: memory_game

export_include_dirs:
  - logic

sources:
  - files:
      - logic/game_pkg.sv
      - logic/video_pkg.sv
      - logic/start_button.sv
      - logic/key_chord_decoder.sv
      - logic/game_fsm.sv
      - logic/tile_board.sv
      - logic/vga_timing.sv
      - logic/tile_renderer.sv
      - logic/memory_game_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_memory_game.sv

//--- logic/game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               start_pulse_i,
    input  wire game_pkg::key_cmd_t cmd_i,
    input  wire logic               all_matched_i,
    output game_pkg::game_state_e   state_o,
    output logic                    pass_o
);

    game_pkg::game_state_e next_state;
    logic                  finish_req;

    assign finish_req = cmd_i.valid && cmd_i.kind == game_pkg::CMD_ENTER && all_matched_i;

    always_comb begin
        next_state = state_o;
        case (state_o)
            game_pkg::INIT:   if (start_pulse_i) next_state = game_pkg::SHOW;
            game_pkg::SHOW:   if (start_pulse_i) next_state = game_pkg::GAME;
            game_pkg::GAME:   if (finish_req) next_state = game_pkg::FINISH;
            game_pkg::FINISH: if (start_pulse_i) next_state = game_pkg::INIT;
            default:          next_state = game_pkg::INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_o <= game_pkg::INIT;
            pass_o  <= 1'b0;
        end else begin
            state_o <= next_state;
            pass_o  <= next_state == game_pkg::FINISH;
        end
    end

endmodule

`default_nettype wire

//--- logic/game_pkg.sv
`default_nettype none

`include "memory_game_macros.svh"

package game_pkg;

    typedef logic [$clog2(`MG_TILES)-1:0] tile_idx_t;
    typedef logic [`MG_TILES-1:0] tile_mask_t;
    typedef logic [7:0] scan_code_t;
    typedef logic [3:0] match_cnt_t;

    typedef enum logic [1:0] {
        INIT,
        SHOW,
        GAME,
        FINISH
    } game_state_e;

    typedef enum logic [1:0] {
        CMD_PAIR,
        CMD_FLIP,
        CMD_ENTER
    } key_cmd_e;

    // tile_b is only meaningful for CMD_PAIR
    typedef struct packed {
        logic      valid;
        key_cmd_e  kind;
        tile_idx_t tile_a;
        tile_idx_t tile_b;
    } key_cmd_t;

endpackage

`default_nettype wire

//--- logic/key_chord_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "memory_game_macros.svh"

module key_chord_decoder (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 key_evt_i,
    input  wire logic                 key_break_i,
    input  wire game_pkg::scan_code_t key_code_i,
    output game_pkg::key_cmd_t        cmd_o
);

    // Returns {is_tile, tile number}
    function automatic logic [4:0] tile_of(input game_pkg::scan_code_t code);
        logic [4:0] r;
        case (code)
            8'h16:   r = {1'b1, 4'd0};
            8'h1E:   r = {1'b1, 4'd1};
            8'h26:   r = {1'b1, 4'd2};
            8'h25:   r = {1'b1, 4'd3};
            8'h15:   r = {1'b1, 4'd4};
            8'h1D:   r = {1'b1, 4'd5};
            8'h24:   r = {1'b1, 4'd6};
            8'h2D:   r = {1'b1, 4'd7};
            8'h1C:   r = {1'b1, 4'd8};
            8'h1B:   r = {1'b1, 4'd9};
            8'h23:   r = {1'b1, 4'd10};
            8'h2B:   r = {1'b1, 4'd11};
            8'h1A:   r = {1'b1, 4'd12};
            8'h22:   r = {1'b1, 4'd13};
            8'h21:   r = {1'b1, 4'd14};
            8'h2A:   r = {1'b1, 4'd15};
            default: r = 5'b0;
        endcase
        return r;
    endfunction

    game_pkg::scan_code_t last_code_q, prev_code_q, p_code;
    logic                 last_held_q, prev_held_q, p_held;
    logic                 make, repeat_make;
    logic [4:0]           c_tile, p_tile;
    logic                 c_shift, p_shift;
    game_pkg::key_cmd_t   cmd_d;

    assign make        = key_evt_i & ~key_break_i;
    // Typematic repeat of the newest key keeps the older key as partner
    assign repeat_make = key_code_i == last_code_q;
    assign p_code      = repeat_make ? prev_code_q : last_code_q;
    assign p_held      = repeat_make ? prev_held_q : last_held_q;
    assign c_tile      = tile_of(key_code_i);
    assign p_tile      = tile_of(p_code);
    assign c_shift     = key_code_i == `MG_KEY_LSHIFT;
    assign p_shift     = p_code == `MG_KEY_LSHIFT;

    always_comb begin
        cmd_d        = '0;
        cmd_d.kind   = game_pkg::CMD_PAIR;
        cmd_d.tile_a = p_tile[3:0];
        cmd_d.tile_b = c_tile[3:0];
        if (make) begin
            if (key_code_i == `MG_KEY_ENTER) begin
                cmd_d.valid = 1'b1;
                cmd_d.kind  = game_pkg::CMD_ENTER;
            end else if (p_held && p_code != key_code_i) begin
                if (c_shift && p_tile[4]) begin
                    cmd_d.valid = 1'b1;
                    cmd_d.kind  = game_pkg::CMD_FLIP;
                end else if (p_shift && c_tile[4]) begin
                    cmd_d.valid  = 1'b1;
                    cmd_d.kind   = game_pkg::CMD_FLIP;
                    cmd_d.tile_a = c_tile[3:0];
                end else if (c_tile[4] && p_tile[4]) begin
                    cmd_d.valid = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_code_q <= '0;
            prev_code_q <= '0;
            last_held_q <= 1'b0;
            prev_held_q <= 1'b0;
            cmd_o       <= '0;
        end else begin
            cmd_o <= cmd_d;
            if (make) begin
                if (!repeat_make) begin
                    prev_code_q <= last_code_q;
                    prev_held_q <= last_held_q;
                    last_code_q <= key_code_i;
                end
                last_held_q <= 1'b1;
            end else if (key_evt_i) begin
                if (key_code_i == last_code_q) begin
                    last_held_q <= 1'b0;
                end
                if (key_code_i == prev_code_q) begin
                    prev_held_q <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/memory_game_macros.svh
`ifndef MEMORY_GAME_MACROS_SVH
`define MEMORY_GAME_MACROS_SVH

// Board
`define MG_TILES        16
`define MG_IMAGES       8
`define MG_PAIRS_TO_WIN 8
`define MG_DEBOUNCE_LEN 7

// Tile size in half-resolution pixels
`define MG_TILE_W 80
`define MG_TILE_H 60

// 640x480 at 60 Hz
`define MG_H_ACTIVE 640
`define MG_H_FRONT  16
`define MG_H_SYNC   96
`define MG_H_TOTAL  800
`define MG_V_ACTIVE 480
`define MG_V_FRONT  10
`define MG_V_SYNC   2
`define MG_V_TOTAL  525

// Set 2 scan codes
`define MG_KEY_ENTER  8'h5A
`define MG_KEY_LSHIFT 8'h12

`endif

//--- logic/memory_game_top.sv
`timescale 1ns/1ps
`default_nettype none

module memory_game_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 start_i,
    input  wire logic                 hint_i,
    input  wire logic                 key_evt_i,
    input  wire logic                 key_break_i,
    input  wire game_pkg::scan_code_t key_code_i,
    input  wire video_pkg::rgb_t      img_data_i,
    output video_pkg::img_idx_t       img_idx_o,
    output video_pkg::img_addr_t      img_addr_o,
    output video_pkg::rgb_t           rgb_o,
    output logic                      hsync_o,
    output logic                      vsync_o,
    output game_pkg::game_state_e     state_o,
    output logic                      pass_o,
    output game_pkg::tile_mask_t      tile_shown_o,
    output game_pkg::tile_mask_t      tile_flip_o
);

    logic                   start_pulse, all_matched, hsync_raw, vsync_raw;
    game_pkg::key_cmd_t     cmd;
    game_pkg::tile_mask_t   shown, matched;
    video_pkg::screen_pos_t pos;

    start_button u_start_button (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start_i),
        .start_pulse_o (start_pulse)
    );

    key_chord_decoder u_key_chord_decoder (
        .clk         (clk),
        .rst         (rst),
        .key_evt_i   (key_evt_i),
        .key_break_i (key_break_i),
        .key_code_i  (key_code_i),
        .cmd_o       (cmd)
    );

    game_fsm u_game_fsm (
        .clk           (clk),
        .rst           (rst),
        .start_pulse_i (start_pulse),
        .cmd_i         (cmd),
        .all_matched_i (all_matched),
        .state_o       (state_o),
        .pass_o        (pass_o)
    );

    tile_board u_tile_board (
        .clk           (clk),
        .rst           (rst),
        .state_i       (state_o),
        .start_pulse_i (start_pulse),
        .hint_i        (hint_i),
        .cmd_i         (cmd),
        .shown_o       (shown),
        .matched_o     (matched),
        .flip_o        (tile_flip_o),
        .all_matched_o (all_matched)
    );

    vga_timing u_vga_timing (
        .clk     (clk),
        .rst     (rst),
        .pos_o   (pos),
        .hsync_o (hsync_raw),
        .vsync_o (vsync_raw)
    );

    tile_renderer u_tile_renderer (
        .clk        (clk),
        .rst        (rst),
        .pos_i      (pos),
        .hsync_i    (hsync_raw),
        .vsync_i    (vsync_raw),
        .state_i    (state_o),
        .hint_i     (hint_i),
        .shown_i    (shown),
        .matched_i  (matched),
        .flip_i     (tile_flip_o),
        .img_data_i (img_data_i),
        .img_idx_o  (img_idx_o),
        .img_addr_o (img_addr_o),
        .rgb_o      (rgb_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o)
    );

    assign tile_shown_o = shown | matched;

endmodule

`default_nettype wire

//--- logic/start_button.sv
`timescale 1ns/1ps
`default_nettype none

`include "memory_game_macros.svh"

module start_button (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start_i,
    output logic      start_pulse_o
);

    logic [`MG_DEBOUNCE_LEN-1:0] samples_q;
    logic                        all_high;
    logic                        all_high_q;

    assign all_high = &samples_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples_q     <= '0;
            all_high_q    <= 1'b0;
            start_pulse_o <= 1'b0;
        end else begin
            samples_q     <= {samples_q[`MG_DEBOUNCE_LEN-2:0], start_i};
            all_high_q    <= all_high;
            // Rising edge of the debounced level
            start_pulse_o <= all_high & ~all_high_q;
        end
    end

endmodule

`default_nettype wire

//--- logic/tile_board.sv
`timescale 1ns/1ps
`default_nettype none

`include "memory_game_macros.svh"

module tile_board (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire game_pkg::game_state_e state_i,
    input  wire logic                  start_pulse_i,
    input  wire logic                  hint_i,
    input  wire game_pkg::key_cmd_t    cmd_i,
    output game_pkg::tile_mask_t       shown_o,
    output game_pkg::tile_mask_t       matched_o,
    output game_pkg::tile_mask_t       flip_o,
    output logic                       all_matched_o
);

    // Tiles 0, 1, 13 and 14 start upside down
    localparam game_pkg::tile_mask_t SHOW_FLIP = 16'h6003;

    game_pkg::match_cnt_t match_cnt_q;
    game_pkg::tile_idx_t  a, b;
    logic                 armed_q;
    logic                 pair_ok, same_img;

    assign a        = cmd_i.tile_a;
    assign b        = cmd_i.tile_b;
    assign pair_ok  = a != b && !matched_o[a] && !matched_o[b];
    // Tile t shows image t mod 8
    assign same_img = a[2:0] == b[2:0] && !flip_o[a] && !flip_o[b];

    assign all_matched_o = match_cnt_q == `MG_PAIRS_TO_WIN;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shown_o     <= '0;
            matched_o   <= '0;
            flip_o      <= '0;
            armed_q     <= 1'b1;
            match_cnt_q <= '0;
        end else begin
            case (state_i)
                game_pkg::INIT: begin
                    shown_o     <= '0;
                    matched_o   <= '0;
                    flip_o      <= '0;
                    armed_q     <= 1'b1;
                    match_cnt_q <= '0;
                end
                game_pkg::SHOW: begin
                    shown_o     <= start_pulse_i ? '0 : '1;
                    matched_o   <= '0;
                    flip_o      <= SHOW_FLIP;
                    armed_q     <= 1'b1;
                    match_cnt_q <= '0;
                end
                game_pkg::GAME: begin
                    if (cmd_i.valid && !hint_i) begin
                        case (cmd_i.kind)
                            game_pkg::CMD_PAIR: begin
                                if (armed_q && pair_ok) begin
                                    shown_o[a] <= 1'b1;
                                    shown_o[b] <= 1'b1;
                                    armed_q    <= 1'b0;
                                    if (same_img) begin
                                        matched_o[a] <= 1'b1;
                                        matched_o[b] <= 1'b1;
                                        match_cnt_q  <= match_cnt_q + 1'b1;
                                    end
                                end
                            end
                            game_pkg::CMD_FLIP: begin
                                if (armed_q && !matched_o[a]) begin
                                    shown_o[a] <= 1'b1;
                                    flip_o[a]  <= ~flip_o[a];
                                    armed_q    <= 1'b0;
                                end
                            end
                            game_pkg::CMD_ENTER: begin
                                if (!armed_q) begin
                                    shown_o <= shown_o & matched_o;
                                    armed_q <= 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                default: shown_o <= '1;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/tile_renderer.sv
`timescale 1ns/1ps
`default_nettype none

`include "memory_game_macros.svh"

module tile_renderer (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire video_pkg::screen_pos_t pos_i,
    input  wire logic                   hsync_i,
    input  wire logic                   vsync_i,
    input  wire game_pkg::game_state_e  state_i,
    input  wire logic                   hint_i,
    input  wire game_pkg::tile_mask_t   shown_i,
    input  wire game_pkg::tile_mask_t   matched_i,
    input  wire game_pkg::tile_mask_t   flip_i,
    input  wire video_pkg::rgb_t        img_data_i,
    output video_pkg::img_idx_t         img_idx_o,
    output video_pkg::img_addr_t        img_addr_o,
    output video_pkg::rgb_t             rgb_o,
    output logic                        hsync_o,
    output logic                        vsync_o
);

    video_pkg::coord_t   x, y;
    logic [1:0]          col, row;
    logic [6:0]          tx;
    logic [5:0]          ty, img_y;
    game_pkg::tile_idx_t tile;
    logic                hint_game, visible, visible_q;

    assign hint_game = hint_i && state_i == game_pkg::GAME;

    always_comb begin
        // Picture is scaled by two
        x     = pos_i.h >> 1;
        y     = pos_i.v >> 1;
        col   = 2'(x / `MG_TILE_W);
        row   = 2'(y / `MG_TILE_H);
        tx    = 7'(x - col * `MG_TILE_W);
        ty    = 6'(y - row * `MG_TILE_H);
        tile  = {row, col};
        img_y = (flip_i[tile] && !hint_game) ? 6'(`MG_TILE_H - 1 - ty) : ty;
    end

    assign img_idx_o  = tile[2:0];
    assign img_addr_o = video_pkg::img_addr_t'(tx)
                      + video_pkg::img_addr_t'(img_y) * video_pkg::img_addr_t'(`MG_TILE_W);

    assign visible = pos_i.active && (shown_i[tile] || matched_i[tile] || hint_game);

    // Line up with the one-cycle memory read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            visible_q <= 1'b0;
            hsync_o   <= 1'b1;
            vsync_o   <= 1'b1;
        end else begin
            visible_q <= visible;
            hsync_o   <= hsync_i;
            vsync_o   <= vsync_i;
        end
    end

    assign rgb_o = visible_q ? img_data_i : '0;

endmodule

`default_nettype wire

//--- logic/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "memory_game_macros.svh"

module vga_timing (
    input  wire logic          clk,
    input  wire logic          rst,
    output video_pkg::screen_pos_t pos_o,
    output logic               hsync_o,
    output logic               vsync_o
);

    localparam int HS_START = `MG_H_ACTIVE + `MG_H_FRONT - 1;
    localparam int VS_START = `MG_V_ACTIVE + `MG_V_FRONT - 1;

    video_pkg::coord_t pix_q, line_q;
    logic              h_act, v_act, line_end;

    assign line_end = pix_q == `MG_H_TOTAL - 1;
    assign h_act    = pix_q < `MG_H_ACTIVE;
    assign v_act    = line_q < `MG_V_ACTIVE;

    assign pos_o.h      = h_act ? pix_q : '0;
    assign pos_o.v      = v_act ? line_q : '0;
    assign pos_o.active = h_act & v_act;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix_q   <= '0;
            line_q  <= '0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            pix_q <= line_end ? '0 : pix_q + 1'b1;
            if (line_end) begin
                line_q <= line_q == `MG_V_TOTAL - 1 ? '0 : line_q + 1'b1;
            end
            // Active-low syncs
            hsync_o <= !(pix_q >= HS_START && pix_q < HS_START + `MG_H_SYNC);
            vsync_o <= !(line_q >= VS_START && line_q < VS_START + `MG_V_SYNC);
        end
    end

endmodule

`default_nettype wire

//--- logic/video_pkg.sv
`default_nettype none

`include "memory_game_macros.svh"

package video_pkg;

    // {red, green, blue}, 4 bits each
    typedef logic [11:0] rgb_t;
    typedef logic [9:0] coord_t;

    typedef struct packed {
        coord_t h;
        coord_t v;
        logic   active;
    } screen_pos_t;

    typedef logic [$clog2(`MG_IMAGES)-1:0] img_idx_t;
    typedef logic [$clog2(`MG_TILE_W * `MG_TILE_H)-1:0] img_addr_t;

endpackage

`default_nettype wire

//--- memory_game.f
+incdir+logic
+incdir+test
logic/game_pkg.sv
logic/video_pkg.sv
logic/start_button.sv
logic/key_chord_decoder.sv
logic/game_fsm.sv
logic/tile_board.sv
logic/vga_timing.sv
logic/tile_renderer.sv
logic/memory_game_top.sv
test/tb_memory_game.sv

//--- test/tb_game_model.svh
`ifndef TB_GAME_MODEL_SVH
`define TB_GAME_MODEL_SVH

// Expected board, shown already includes matched tiles
game_pkg::tile_mask_t exp_shown;
game_pkg::tile_mask_t exp_matched;
game_pkg::tile_mask_t exp_flip;
logic                 exp_armed;
int                   exp_pairs;

// Set 2 codes of 1 2 3 4, Q W E R, A S D F, Z X C V
function automatic game_pkg::scan_code_t key_of_tile(input int t);
    game_pkg::scan_code_t codes [16];
    codes = '{8'h16, 8'h1E, 8'h26, 8'h25, 8'h15, 8'h1D, 8'h24, 8'h2D,
              8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h1A, 8'h22, 8'h21, 8'h2A};
    return codes[t];
endfunction

// Image memory contents
function automatic video_pkg::rgb_t img_color(input int img, input int addr);
    return video_pkg::rgb_t'((addr * 7) ^ (addr >> 5) ^ (img * 'h29b));
endfunction

task automatic clear_expected();
    exp_shown   = '0;
    exp_matched = '0;
    exp_flip    = '0;
    exp_armed   = 1'b1;
    exp_pairs   = 0;
endtask

task automatic reveal_all_expected();
    exp_shown    = '1;
    exp_flip     = '0;
    // Tiles 0, 1, 13 and 14 start upside down
    exp_flip[0]  = 1'b1;
    exp_flip[1]  = 1'b1;
    exp_flip[13] = 1'b1;
    exp_flip[14] = 1'b1;
endtask

task automatic pair_rule(input int a, input int b);
    if (exp_armed && a != b && !exp_matched[a] && !exp_matched[b]) begin
        exp_shown[a] = 1'b1;
        exp_shown[b] = 1'b1;
        exp_armed    = 1'b0;
        if (a % `MG_IMAGES == b % `MG_IMAGES && !exp_flip[a] && !exp_flip[b]) begin
            exp_matched[a] = 1'b1;
            exp_matched[b] = 1'b1;
            exp_pairs++;
        end
    end
endtask

task automatic flip_rule(input int t);
    if (exp_armed && !exp_matched[t]) begin
        exp_shown[t] = 1'b1;
        exp_flip[t]  = ~exp_flip[t];
        exp_armed    = 1'b0;
    end
endtask

task automatic enter_rule();
    if (!exp_armed) begin
        exp_shown = exp_shown & exp_matched;
        exp_armed = 1'b1;
    end
endtask

// Color of screen pixel (h, v) outside the hint mode
function automatic video_pkg::rgb_t pixel_rgb(input int h, input int v);
    int x;
    int y;
    int tile;
    int ty;
    if (h >= `MG_H_ACTIVE || v >= `MG_V_ACTIVE) begin
        return '0;
    end
    x    = h / 2;
    y    = v / 2;
    tile = (y / `MG_TILE_H) * 4 + x / `MG_TILE_W;
    ty   = y % `MG_TILE_H;
    if (!exp_shown[tile]) begin
        return '0;
    end
    if (exp_flip[tile]) begin
        ty = `MG_TILE_H - 1 - ty;
    end
    return img_color(tile % `MG_IMAGES, x % `MG_TILE_W + ty * `MG_TILE_W);
endfunction

`endif

//--- test/tb_memory_game.sv
`timescale 1ns/1ps
`default_nettype none

`include "memory_game_macros.svh"

module tb_memory_game;

    localparam int FRAME_CYCLES   = `MG_H_TOTAL * `MG_V_TOTAL;
    // Two scanned frames plus the key tests, with a frame to spare
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 4000;
    localparam int RANDOM_CHORDS  = 24;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  hint;
    logic                  key_evt;
    logic                  key_break;
    game_pkg::scan_code_t  key_code;
    video_pkg::rgb_t       img_data;
    video_pkg::img_idx_t   img_idx;
    video_pkg::img_addr_t  img_addr;
    video_pkg::rgb_t       rgb;
    logic                  hsync;
    logic                  vsync;
    game_pkg::game_state_e state;
    logic                  pass;
    game_pkg::tile_mask_t  tile_shown;
    game_pkg::tile_mask_t  tile_flip;
    integer                seed;
    int                    cyc = 0;

    `include "tb_game_model.svh"

    memory_game_top u_memory_game_top (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start),
        .hint_i       (hint),
        .key_evt_i    (key_evt),
        .key_break_i  (key_break),
        .key_code_i   (key_code),
        .img_data_i   (img_data),
        .img_idx_o    (img_idx),
        .img_addr_o   (img_addr),
        .rgb_o        (rgb),
        .hsync_o      (hsync),
        .vsync_o      (vsync),
        .state_o      (state),
        .pass_o       (pass),
        .tile_shown_o (tile_shown),
        .tile_flip_o  (tile_flip)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Cycles since reset release, equal to the scan position
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
            if (cyc >= TIMEOUT_CYCLES) begin
                $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
                $display("CHECKS FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    // Image memory with one cycle of read latency
    initial begin
        video_pkg::rgb_t rd_data;
        img_data = '0;
        forever begin
            @(negedge clk);
            rd_data = img_color(img_idx, img_addr);
            @(posedge clk);
            #2;
            img_data = rd_data;
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic settle(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic check_board();
        check_eq("tile_shown_o", tile_shown, exp_shown);
        check_eq("tile_flip_o", tile_flip, exp_flip);
    endtask

    task automatic key_event(input game_pkg::scan_code_t code, input logic brk);
        key_code  = code;
        key_break = brk;
        key_evt   = 1'b1;
        settle(1);
        key_evt   = 1'b0;
        key_break = 1'b0;
    endtask

    task automatic press_chord(input game_pkg::scan_code_t first,
                               input game_pkg::scan_code_t second);
        key_event(first, 1'b0);
        key_event(second, 1'b0);
        key_event(second, 1'b1);
        key_event(first, 1'b1);
    endtask

    task automatic play_pair(input int a, input int b);
        press_chord(key_of_tile(a), key_of_tile(b));
        pair_rule(a, b);
        settle(2);
        check_board();
    endtask

    task automatic toggle_flip(input int t);
        press_chord(`MG_KEY_LSHIFT, key_of_tile(t));
        flip_rule(t);
        settle(2);
        check_board();
    endtask

    task automatic send_enter();
        key_event(`MG_KEY_ENTER, 1'b0);
        key_event(`MG_KEY_ENTER, 1'b1);
        enter_rule();
        settle(2);
        check_board();
    endtask

    task automatic press_start(input game_pkg::game_state_e next);
        int n;
        n     = 0;
        start = 1'b1;
        while (state != next && n < 30) begin
            settle(1);
            n++;
        end
        if (state != next) begin
            $display("Start button did not move the game to state %0d", next);
            $display("CHECKS FAILED");
            $fatal(1, "start press timed out");
        end
        start = 1'b0;
        settle(10);
    endtask

    // One full frame of syncs and pixels
    task automatic scan_frame();
        int h_low;
        int v_low;
        int p;
        h_low = 0;
        v_low = 0;
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            if (!hsync) h_low++;
            if (!vsync) v_low++;
            // rgb_o trails the scan position by one clock
            p = cyc - 1;
            check_eq("rgb_o", rgb,
                     pixel_rgb(p % `MG_H_TOTAL, (p / `MG_H_TOTAL) % `MG_V_TOTAL));
        end
        check_eq("hsync_o low cycles", h_low, `MG_H_SYNC * `MG_V_TOTAL);
        check_eq("vsync_o low cycles", v_low, `MG_V_SYNC * `MG_H_TOTAL);
        settle(1);
    endtask

    initial begin
        int a;
        int b;
        seed      = 32'h3402e8f5;
        rst       = 1'b1;
        start     = 1'b0;
        hint      = 1'b0;
        key_evt   = 1'b0;
        key_break = 1'b0;
        key_code  = '0;
        clear_expected();
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        settle(2);

        check_eq("state_o", state, game_pkg::INIT);
        check_eq("pass_o", pass, 1'b0);
        check_board();
        scan_frame();
        press_start(game_pkg::SHOW);
        reveal_all_expected();
        check_board();
        scan_frame();
        press_start(game_pkg::GAME);
        exp_shown = '0;
        check_board();

        for (int i = 0; i < RANDOM_CHORDS; i++) begin
            a = $unsigned($random(seed)) % `MG_TILES;
            b = $unsigned($random(seed)) % `MG_TILES;
            play_pair(a, b);
            send_enter();
        end

        // Tile 0 starts flipped, so its pair is still open
        toggle_flip(0);
        send_enter();
        play_pair(0, 8);
        send_enter();
        check_eq("tile_shown_o[0]", tile_shown[0], 1'b1);
        check_eq("tile_shown_o[8]", tile_shown[8], 1'b1);

        // Partners of tiles 5, 6 and 9 are still flipped so these tiles are open
        hint = 1'b1;
        press_chord(key_of_tile(6), key_of_tile(9));
        settle(2);
        check_board();
        press_chord(`MG_KEY_LSHIFT, key_of_tile(5));
        settle(2);
        check_board();
        key_event(`MG_KEY_ENTER, 1'b0);
        key_event(`MG_KEY_ENTER, 1'b1);
        settle(2);
        check_board();
        hint = 1'b0;

        for (int t = 0; t < `MG_TILES; t++) begin
            if (exp_flip[t]) begin
                toggle_flip(t);
                send_enter();
            end
        end
        for (int p = 0; p < `MG_IMAGES; p++) begin
            if (!exp_matched[p]) begin
                play_pair(p, p + `MG_IMAGES);
                if (exp_pairs < `MG_PAIRS_TO_WIN) begin
                    send_enter();
                end
            end
        end
        send_enter();
        check_eq("state_o", state, game_pkg::FINISH);
        check_eq("pass_o", pass, 1'b1);
        check_eq("tile_shown_o", tile_shown, 16'hFFFF);
        press_start(game_pkg::INIT);
        clear_expected();
        check_eq("pass_o", pass, 1'b0);
        check_board();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
